// ==== hdl/commu_m_pkg.sv ====
// shared bus and payload types plus the register map, used by every commu_m block
package commu_m_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int N_CH = 8;
	localparam int CH_W = $clog2(N_CH);

	// debug scratch registers
	localparam int N_DBG = 8;
	localparam int DBG_W = $clog2(N_DBG);

	// --------------------------------------------------
	// register offsets, low byte of the fx address
	// --------------------------------------------------
	localparam logic [7:0] ADDR_ID   = 8'h00;
	localparam logic [7:0] ADDR_RDY  = 8'h30;
	localparam logic [7:0] ADDR_TP   = 8'h40;
	localparam logic [7:0] ADDR_DBG0 = 8'h80;

	// debug register i comes out of reset as base plus i
	localparam logic [7:0] DBG_RST_BASE = 8'h80;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	// host side register access, write and read halves
	typedef struct packed {
		logic        wr;
		logic [15:0] waddr;
		logic [7:0]  data;
		logic        rd;
		logic [15:0] raddr;
	} fx_req_t;

	// one buffered status word
	typedef struct packed {
		logic [3:0] seq;
		logic [7:0] data;
	} stu_word_t;

	// word as it leaves on the host link
	typedef struct packed {
		logic [2:0] ch;
		logic [3:0] seq;
		logic [7:0] data;
	} up_word_t;

endpackage

// ==== hdl/commu_m_reg.sv ====
// fx bus register block: module id decode, channel enable mask, debug scratch and status readback
`timescale 1ns/1ps

module commu_m_reg (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  commu_m_pkg::fx_req_t  fx_req,
	input  logic [5:0]            mod_id,
	input  logic [7:0]            stu_buf_rdy,
	output logic [7:0]            fx_q,
	output logic [7:0]            cfg_tp
);

	// --------------------------------------------------
	// module select
	// --------------------------------------------------
	logic now_wr;
	logic now_rd;
	logic wr_dbg;
	logic rd_dbg;
	logic [commu_m_pkg::DBG_W-1:0] dbg_widx;
	logic [commu_m_pkg::DBG_W-1:0] dbg_ridx;
	logic [7:0] dbg [commu_m_pkg::N_DBG];

	assign now_wr = fx_req.wr && (fx_req.waddr[13:8] == mod_id);
	assign now_rd = fx_req.rd && (fx_req.raddr[13:8] == mod_id);

	// debug window is an aligned block starting at ADDR_DBG0
	assign wr_dbg = (fx_req.waddr[7:0] >= commu_m_pkg::ADDR_DBG0) &&
		(fx_req.waddr[7:0] < commu_m_pkg::ADDR_DBG0 + 8'(commu_m_pkg::N_DBG));
	assign rd_dbg = (fx_req.raddr[7:0] >= commu_m_pkg::ADDR_DBG0) &&
		(fx_req.raddr[7:0] < commu_m_pkg::ADDR_DBG0 + 8'(commu_m_pkg::N_DBG));

	assign dbg_widx = commu_m_pkg::DBG_W'(fx_req.waddr[7:0] - commu_m_pkg::ADDR_DBG0);
	assign dbg_ridx = commu_m_pkg::DBG_W'(fx_req.raddr[7:0] - commu_m_pkg::ADDR_DBG0);

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			// all channels start disabled
			cfg_tp <= 8'h00;
			for (int i = 0; i < commu_m_pkg::N_DBG; i++) begin
				dbg[i] <= commu_m_pkg::DBG_RST_BASE + 8'(i);
			end
		end else if (now_wr) begin
			if (fx_req.waddr[7:0] == commu_m_pkg::ADDR_TP) begin
				cfg_tp <= fx_req.data;
			end else if (wr_dbg) begin
				dbg[dbg_widx] <= fx_req.data;
			end
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// one cycle pulse, zero whenever no read is selected
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fx_q <= 8'h00;
		end else if (now_rd) begin
			case (fx_req.raddr[7:0])
				commu_m_pkg::ADDR_ID:  fx_q <= {2'b00, mod_id};
				commu_m_pkg::ADDR_RDY: fx_q <= stu_buf_rdy;
				commu_m_pkg::ADDR_TP:  fx_q <= cfg_tp;
				default: begin
					if (rd_dbg) begin
						fx_q <= dbg[dbg_ridx];
					end else begin
						// unmapped offset
						fx_q <= 8'h00;
					end
				end
			endcase
		end else begin
			fx_q <= 8'h00;
		end
	end

endmodule

// ==== hdl/commu_m_stu_cap.sv ====
// status capture stage: registers each incoming strobe and stamps it with its channel's sequence count
`timescale 1ns/1ps

module commu_m_stu_cap (
	input  logic                              clk_sys,
	input  logic                              rst_n,
	input  logic                              stu_vld,
	input  logic [commu_m_pkg::CH_W-1:0]      stu_ch,
	input  logic [7:0]                        stu_data,
	output logic                              buf_we,
	output logic [commu_m_pkg::CH_W-1:0]      buf_ch,
	output commu_m_pkg::stu_word_t            buf_word
);

	// one counter per channel, wraps at 16
	logic [3:0] seq_cnt [commu_m_pkg::N_CH];

	// --------------------------------------------------
	// strobe and sequence counters
	// --------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			buf_we <= 1'b0;
			for (int i = 0; i < commu_m_pkg::N_CH; i++) begin
				seq_cnt[i] <= 4'd0;
			end
		end else begin
			buf_we <= stu_vld;
			if (stu_vld) begin
				seq_cnt[stu_ch] <= seq_cnt[stu_ch] + 4'd1;
			end
		end
	end

	// --------------------------------------------------
	// payload
	// --------------------------------------------------
	// word carries the count before the increment
	always_ff @(posedge clk_sys) begin
		if (stu_vld) begin
			buf_ch        <= stu_ch;
			buf_word.seq  <= seq_cnt[stu_ch];
			buf_word.data <= stu_data;
		end
	end

endmodule

// ==== hdl/commu_m_stu_buf.sv ====
// status buffer: one word slot per channel with ready flags, a new word overwrites an unread one
`timescale 1ns/1ps

module commu_m_stu_buf (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          buf_we,
	input  logic [commu_m_pkg::CH_W-1:0]  buf_ch,
	input  commu_m_pkg::stu_word_t        buf_word,
	input  logic                          clr_vld,
	input  logic [commu_m_pkg::CH_W-1:0]  clr_ch,
	output logic [commu_m_pkg::N_CH-1:0]  slot_rdy,
	output commu_m_pkg::stu_word_t        slots [commu_m_pkg::N_CH]
);

	// --------------------------------------------------
	// ready flags
	// --------------------------------------------------
	// write beats clear on the same slot
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			slot_rdy <= '0;
		end else begin
			for (int i = 0; i < commu_m_pkg::N_CH; i++) begin
				if (buf_we && (buf_ch == commu_m_pkg::CH_W'(i))) begin
					slot_rdy[i] <= 1'b1;
				end else if (clr_vld && (clr_ch == commu_m_pkg::CH_W'(i))) begin
					slot_rdy[i] <= 1'b0;
				end
			end
		end
	end

	// --------------------------------------------------
	// slot storage
	// --------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (buf_we) begin
			slots[buf_ch] <= buf_word;
		end
	end

endmodule

// ==== hdl/commu_m_upload.sv ====
// round-robin uploader: drains ready, enabled slots to the host link unless the link is busy
`timescale 1ns/1ps

module commu_m_upload (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [commu_m_pkg::N_CH-1:0]  slot_rdy,
	input  commu_m_pkg::stu_word_t        slots [commu_m_pkg::N_CH],
	input  logic [7:0]                    cfg_tp,
	input  logic                          up_busy,
	output logic                          clr_vld,
	output logic [commu_m_pkg::CH_W-1:0]  clr_ch,
	output logic                          up_vld,
	output commu_m_pkg::up_word_t         up_word
);

	logic [commu_m_pkg::N_CH-1:0] cand;
	logic [commu_m_pkg::CH_W-1:0] last_ch;
	logic [commu_m_pkg::CH_W-1:0] pick;
	logic [commu_m_pkg::CH_W-1:0] idx;
	logic                         found;
	logic                         issue;

	// --------------------------------------------------
	// arbitration
	// --------------------------------------------------
	assign cand = slot_rdy & cfg_tp;

	// search starts one past the last served channel
	always_comb begin
		found = 1'b0;
		pick  = '0;
		idx   = '0;
		for (int k = 1; k <= commu_m_pkg::N_CH; k++) begin
			idx = last_ch + commu_m_pkg::CH_W'(k);
			if (!found && cand[idx]) begin
				found = 1'b1;
				pick  = idx;
			end
		end
	end

	assign issue = found && !up_busy;

	// slot drops on the same edge the upload registers
	assign clr_vld = issue;
	assign clr_ch  = pick;

	// --------------------------------------------------
	// upload register and pointer
	// --------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			up_vld  <= 1'b0;
			// first search then begins at channel 0
			last_ch <= commu_m_pkg::CH_W'(commu_m_pkg::N_CH - 1);
		end else begin
			up_vld <= issue;
			if (issue) begin
				last_ch <= pick;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue) begin
			up_word <= {pick, slots[pick]};
		end
	end

endmodule

// ==== hdl/commu_m_top.sv ====
// commu_m top level: fx register block, status capture, slot buffer and uploader wired together
`timescale 1ns/1ps

module commu_m_top (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  commu_m_pkg::fx_req_t          fx_req,
	input  logic [5:0]                    mod_id,
	input  logic                          stu_vld,
	input  logic [commu_m_pkg::CH_W-1:0]  stu_ch,
	input  logic [7:0]                    stu_data,
	input  logic                          up_busy,
	output logic [7:0]                    fx_q,
	output logic [7:0]                    cfg_tp,
	output logic                          up_vld,
	output commu_m_pkg::up_word_t         up_word
);

	// capture to buffer
	logic                          buf_we;
	logic [commu_m_pkg::CH_W-1:0]  buf_ch;
	commu_m_pkg::stu_word_t        buf_word;

	// buffer to uploader and register block
	logic [commu_m_pkg::N_CH-1:0]  slot_rdy;
	commu_m_pkg::stu_word_t        slots [commu_m_pkg::N_CH];

	// uploader back to buffer
	logic                          clr_vld;
	logic [commu_m_pkg::CH_W-1:0]  clr_ch;

	// --------------------------------------------------
	// instances
	// --------------------------------------------------
	commu_m_reg u_reg (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fx_req      (fx_req),
		.mod_id      (mod_id),
		.stu_buf_rdy (slot_rdy),
		.fx_q        (fx_q),
		.cfg_tp      (cfg_tp)
	);

	commu_m_stu_cap u_cap (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.stu_vld  (stu_vld),
		.stu_ch   (stu_ch),
		.stu_data (stu_data),
		.buf_we   (buf_we),
		.buf_ch   (buf_ch),
		.buf_word (buf_word)
	);

	commu_m_stu_buf u_buf (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.buf_we   (buf_we),
		.buf_ch   (buf_ch),
		.buf_word (buf_word),
		.clr_vld  (clr_vld),
		.clr_ch   (clr_ch),
		.slot_rdy (slot_rdy),
		.slots    (slots)
	);

	commu_m_upload u_up (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.slot_rdy (slot_rdy),
		.slots    (slots),
		.cfg_tp   (cfg_tp),
		.up_busy  (up_busy),
		.clr_vld  (clr_vld),
		.clr_ch   (clr_ch),
		.up_vld   (up_vld),
		.up_word  (up_word)
	);

endmodule

// ==== sim/commu_m_chk.sv ====
// concurrent assertions on upload issue rules and the fx read pulse, bound into the top level
`timescale 1ns/1ps

module commu_m_chk (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  commu_m_pkg::fx_req_t  fx_req,
	input  logic [5:0]            mod_id,
	input  logic [7:0]            fx_q,
	input  logic [7:0]            slot_rdy,
	input  logic [7:0]            cfg_tp,
	input  logic                  up_busy,
	input  logic                  up_vld,
	input  commu_m_pkg::up_word_t up_word
);

	logic       rd_sel;
	logic [7:0] cand_q;

	assign rd_sel = fx_req.rd && (fx_req.raddr[13:8] == mod_id);

	// candidates seen on the edge that issued the upload
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cand_q <= 8'h00;
		end else begin
			cand_q <= slot_rdy & cfg_tp;
		end
	end

	a_busy_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		up_busy |=> !up_vld)
		else $error("upload issued after an edge with the link busy");

	a_ready_enabled: assert property (@(posedge clk_sys) disable iff (!rst_n)
		up_vld |-> cand_q[up_word.ch])
		else $error("upload from a slot that was not ready and enabled");

	a_fx_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rd_sel |=> (fx_q == 8'h00))
		else $error("fx_q nonzero without a selected read");

endmodule

bind commu_m_top commu_m_chk u_chk (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.fx_req   (fx_req),
	.mod_id   (mod_id),
	.fx_q     (fx_q),
	.slot_rdy (slot_rdy),
	.cfg_tp   (cfg_tp),
	.up_busy  (up_busy),
	.up_vld   (up_vld),
	.up_word  (up_word)
);

// ==== sim/commu_m_mon.sv ====
// checking module that models registers, capture stage and slots and compares fx_q and uploads
`timescale 1ns/1ps

module commu_m_mon (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  commu_m_pkg::fx_req_t  fx_req,
	input  logic [5:0]            mod_id,
	input  logic                  stu_vld,
	input  logic [2:0]            stu_ch,
	input  logic [7:0]            stu_data,
	input  logic                  up_busy,
	input  logic [7:0]            fx_q,
	input  logic [7:0]            cfg_tp,
	input  logic                  up_vld,
	input  commu_m_pkg::up_word_t up_word,
	input  logic                  end_chk,
	output int                    err_cnt,
	output int                    chk_cnt
);

	logic [7:0]  m_tp;
	logic [7:0]  m_dbg [8];
	logic [7:0]  m_rdy;
	logic [11:0] m_word [8];
	logic [3:0]  m_seq [8];
	logic [2:0]  m_last;
	// word in flight between strobe and slot
	logic        cap_vld;
	logic [2:0]  cap_ch;
	logic [11:0] cap_word;
	logic [7:0]  exp_q;
	logic        exp_vld;
	logic [14:0] exp_word;
	int          errs = 0;
	int          checks = 0;

	assign err_cnt = errs;
	assign chk_cnt = checks;

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (exp !== act) begin
			errs++;
			$display("[FAIL] %s expected %0h actual %0h at %0t", name, exp, act, $time);
		end
	endtask

	always @(posedge clk_sys or negedge rst_n) begin : model
		logic [7:0] cand;
		logic [7:0] off;
		logic [2:0] idx;
		if (!rst_n) begin
			m_tp    = 8'h00;
			m_rdy   = 8'h00;
			m_last  = 3'd7;
			cap_vld = 1'b0;
			exp_q   = 8'h00;
			exp_vld = 1'b0;
			for (int i = 0; i < 8; i++) begin
				m_dbg[i] = commu_m_pkg::DBG_RST_BASE + 8'(i);
				m_seq[i] = 4'd0;
			end
		end else begin
			// --------------------------------------------------
			// outputs from the previous edge
			// --------------------------------------------------
			compare("fx_q", 16'(exp_q), 16'(fx_q));
			compare("cfg_tp", 16'(m_tp), 16'(cfg_tp));
			compare("up_vld", 16'(exp_vld), 16'(up_vld));
			if (exp_vld) begin
				compare("up_word", 16'(exp_word), 16'(up_word));
			end
			// ready readback after the drain shows no channel left
			if (end_chk) begin
				compare("drain ready", 16'd0, 16'(fx_q));
			end

			// --------------------------------------------------
			// next expectations from pre-edge state
			// --------------------------------------------------
			off   = fx_req.raddr[7:0];
			exp_q = 8'h00;
			if (fx_req.rd && fx_req.raddr[13:8] == mod_id) begin
				if (off == commu_m_pkg::ADDR_ID) begin
					exp_q = {2'b00, mod_id};
				end else if (off == commu_m_pkg::ADDR_RDY) begin
					exp_q = m_rdy;
				end else if (off == commu_m_pkg::ADDR_TP) begin
					exp_q = m_tp;
				end else if (off[7:3] == 5'b10000) begin
					exp_q = m_dbg[off[2:0]];
				end
			end

			// next ready, enabled channel after the last one served
			cand    = m_rdy & m_tp;
			exp_vld = 1'b0;
			if (!up_busy) begin
				for (int k = 1; k <= 8; k++) begin
					idx = m_last + 3'(k);
					if (!exp_vld && cand[idx]) begin
						exp_vld     = 1'b1;
						exp_word    = {idx, m_word[idx]};
						m_rdy[idx]  = 1'b0;
						m_last      = idx;
					end
				end
			end

			// a slot write after the clear, so the write wins
			if (cap_vld) begin
				m_word[cap_ch] = cap_word;
				m_rdy[cap_ch]  = 1'b1;
			end
			cap_vld = stu_vld;
			if (stu_vld) begin
				cap_ch        = stu_ch;
				cap_word      = {m_seq[stu_ch], stu_data};
				m_seq[stu_ch] = m_seq[stu_ch] + 4'd1;
			end

			if (fx_req.wr && fx_req.waddr[13:8] == mod_id) begin
				if (fx_req.waddr[7:0] == commu_m_pkg::ADDR_TP) begin
					m_tp = fx_req.data;
				end else if (fx_req.waddr[7:3] == 5'b10000) begin
					m_dbg[fx_req.waddr[2:0]] = fx_req.data;
				end
			end
		end
	end

endmodule

// ==== sim/commu_m_tb.sv ====
// testbench top for commu_m: clock, reset, LFSR register and status traffic, watchdog, verdict
`timescale 1ns/1ps

module commu_m_tb;

	localparam int CLK_NS = 8;
	localparam int RST_CYC = 10;
	localparam int REG_CYC = 200;
	localparam int TRAF_CYC = 600;
	localparam int DRAIN_CYC = 40;
	localparam int TIMEOUT_NS = (RST_CYC + REG_CYC + TRAF_CYC + DRAIN_CYC + 200) * CLK_NS;
	localparam logic [5:0] STRAP_ID = 6'h2a;

	logic                  clk_sys;
	logic                  rst_n;
	commu_m_pkg::fx_req_t  fx_req;
	logic [5:0]            mod_id;
	logic                  stu_vld;
	logic [2:0]            stu_ch;
	logic [7:0]            stu_data;
	logic                  up_busy;
	logic [7:0]            fx_q;
	logic [7:0]            cfg_tp;
	logic                  up_vld;
	commu_m_pkg::up_word_t up_word;
	logic                  end_chk;
	int                    err_cnt;
	int                    chk_cnt;
	logic [15:0]           lfsr;

	commu_m_top u_commu_m_top (
		.clk_sys (clk_sys), .rst_n (rst_n), .fx_req (fx_req), .mod_id (mod_id),
		.stu_vld (stu_vld), .stu_ch (stu_ch), .stu_data (stu_data), .up_busy (up_busy),
		.fx_q (fx_q), .cfg_tp (cfg_tp), .up_vld (up_vld), .up_word (up_word)
	);

	commu_m_mon u_mon (
		.clk_sys (clk_sys), .rst_n (rst_n), .fx_req (fx_req), .mod_id (mod_id),
		.stu_vld (stu_vld), .stu_ch (stu_ch), .stu_data (stu_data), .up_busy (up_busy),
		.fx_q (fx_q), .cfg_tp (cfg_tp), .up_vld (up_vld), .up_word (up_word),
		.end_chk (end_chk), .err_cnt (err_cnt), .chk_cnt (chk_cnt)
	);

	// 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	// --------------------------------------------------
	// bus helpers
	// --------------------------------------------------
	// strobe held for one cycle, then an idle cycle
	task automatic bus_access(input logic wr, input logic [5:0] id, input logic [7:0] off,
		input logic [7:0] d);
		@(posedge clk_sys);
		fx_req.wr    <= wr;
		fx_req.waddr <= {2'b00, id, off};
		fx_req.data  <= d;
		fx_req.rd    <= !wr;
		fx_req.raddr <= {2'b00, id, off};
		@(posedge clk_sys);
		fx_req.wr <= 1'b0;
		fx_req.rd <= 1'b0;
	endtask

	task automatic read_all(input logic [5:0] id);
		bus_access(1'b0, id, commu_m_pkg::ADDR_ID, 8'h00);
		bus_access(1'b0, id, commu_m_pkg::ADDR_RDY, 8'h00);
		bus_access(1'b0, id, commu_m_pkg::ADDR_TP, 8'h00);
		for (int i = 0; i < 8; i++) begin
			bus_access(1'b0, id, commu_m_pkg::ADDR_DBG0 + 8'(i), 8'h00);
		end
		// nothing mapped here
		bus_access(1'b0, id, 8'h55, 8'h00);
	endtask

	task automatic random_writes(input int n);
		logic [15:0] r;
		logic [15:0] d;
		logic [15:0] o;
		logic [5:0]  id;
		logic [7:0]  off;
		for (int i = 0; i < n; i++) begin
			r = rand_bits(4);
			d = rand_bits(8);
			o = rand_bits(8);
			// a quarter go to another module
			id = (r[1:0] == 2'd0) ? (mod_id ^ 6'h15) : mod_id;
			case (r[3:2])
				2'd0: off = commu_m_pkg::ADDR_TP;
				2'd3: off = o[7:0];
				default: off = commu_m_pkg::ADDR_DBG0 + {5'd0, o[2:0]};
			endcase
			bus_access(1'b1, id, off, d[7:0]);
		end
	endtask

	// --------------------------------------------------
	// status traffic
	// --------------------------------------------------
	task automatic traffic(input int n);
		logic [15:0] r;
		for (int i = 0; i < n; i++) begin
			r = rand_bits(16);
			@(posedge clk_sys);
			stu_vld      <= r[0];
			stu_ch       <= r[3:1];
			stu_data     <= r[11:4];
			up_busy      <= (r[13:12] == 2'd0);
			fx_req.rd    <= (r[15:14] == 2'd0);
			fx_req.raddr <= {2'b00, mod_id, commu_m_pkg::ADDR_RDY};
		end
		@(posedge clk_sys);
		stu_vld   <= 1'b0;
		up_busy   <= 1'b0;
		fx_req.rd <= 1'b0;
	endtask

	initial begin
		logic [15:0] mask;
		lfsr     = 16'd16;
		rst_n    = 1'b0;
		fx_req   = '0;
		mod_id   = STRAP_ID;
		stu_vld  = 1'b0;
		stu_ch   = 3'd0;
		stu_data = 8'h00;
		up_busy  = 1'b0;
		end_chk  = 1'b0;
		repeat (RST_CYC) @(posedge clk_sys);
		rst_n <= 1'b1;

		read_all(mod_id);
		read_all(mod_id ^ 6'h15);
		random_writes(40);
		read_all(mod_id);
		read_all(mod_id ^ 6'h15);

		traffic(TRAF_CYC / 2);
		mask = rand_bits(8);
		bus_access(1'b1, mod_id, commu_m_pkg::ADDR_TP, mask[7:0]);
		traffic(TRAF_CYC / 2);

		// quiet drain with every channel enabled
		bus_access(1'b1, mod_id, commu_m_pkg::ADDR_TP, 8'hff);
		repeat (DRAIN_CYC) @(posedge clk_sys);
		bus_access(1'b0, mod_id, commu_m_pkg::ADDR_RDY, 8'h00);
		end_chk <= 1'b1;
		@(posedge clk_sys);
		end_chk <= 1'b0;
		repeat (4) @(posedge clk_sys);

		$display("commu_m_tb: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, test sequence did not finish", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/commu_m_pkg.sv
hdl/commu_m_reg.sv
hdl/commu_m_stu_cap.sv
hdl/commu_m_stu_buf.sv
hdl/commu_m_upload.sv
hdl/commu_m_top.sv
sim/commu_m_chk.sv
sim/commu_m_mon.sv
sim/commu_m_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and pass only if the pass message is printed
set -e
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module commu_m_tb -f build.f -o commu_m_sim
./obj_dir/commu_m_sim | tee /dev/stderr | grep -qF "Simulation completed successfully"
